/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

# --assert turns on the bound protocol checks
verilator --binary --timing --assert -Wno-fatal \
	--top-module l2TileCache_tb -f sources.f -o simv

# an assertion stop ends the run early, the log search still decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
	echo "run.sh: simulation PASS"
	exit 0
fi
echo "run.sh: simulation FAIL"
exit 1

/* sources.f */
+incdir+verilog
verilog/l2TilePkg.sv
verilog/tileStore.sv
verilog/transferTimer.sv
verilog/tileAssembler.sv
verilog/missSequencer.sv
verilog/l2TileCache.sv
verif/l2TileCache_assertions.sv
verif/l2TileCache_tb.sv

/* verif/l2TileCache_assertions.sv */
`timescale 1ns/1ps

module l2TileCacheAssertions (
	input logic                clock,
	input logic                rstN,
	input l2TilePkg::memOpm_e  memOpm,
	input l2TilePkg::memOk_e   memOk,
	input l2TilePkg::ddrCmd_s  ddrCmd,
	input l2TilePkg::memOk_e   ddrOk,
	input logic                expired
);
	import l2TilePkg::*;

	// an idle requester cycle leaves the cache idle on the next one
	idleAnswer: assert property (@(posedge clock) disable iff (!rstN)
		memOpm == OPM_READY |=> memOk == OK_READY)
		else $error("memOk left READY while the requester was idle");

	// a stalled beat keeps its command until the watchdog gives up
	holdStable: assert property (@(posedge clock) disable iff (!rstN)
		(ddrOk == OK_HOLD && !expired) |=> $stable(ddrCmd))
		else $error("ddrCmd changed while DDR answered HOLD");

	newBeat: assert property (@(posedge clock) disable iff (!rstN)
		(ddrCmd.opm != OPM_READY && $past(ddrCmd.opm) == OPM_READY)
			|-> $past(ddrOk) == OK_READY)
		else $error("DDR beat issued before ddrOk returned to READY");

	faultCause: assert property (@(posedge clock) disable iff (!rstN)
		memOk == OK_FAULT |-> $past(expired))
		else $error("FAULT answered without a watchdog expiry");

endmodule

bind l2TileCache l2TileCacheAssertions protocolCheck (
	.clock, .rstN, .memOpm, .memOk, .ddrCmd, .ddrOk, .expired
);

/* verif/l2TileCache_tb.sv */
`timescale 1ns/1ps
`include "l2Tile_defines.svh"

module l2TileCache_tb;
	import l2TilePkg::*;

	localparam string tracePath = "verif/l2TileCache_trace.txt";
	localparam int clockPeriod = 4;
	localparam int maxReqCycles = 2 * `L2_BEATS * (`L2_DDR_TIMEOUT + 4) + 8;    // writeback plus fill

	typedef struct packed
	{
		logic        isWrite;
		logic [31:0] addr;
		tileWord_u   wrTile;
		logic        expFault;
		tileWord_u   expTile;
		int          stall;
		int          wrBeats;
		int          rdBeats;
	} traceEntry_s;

	typedef enum logic [1:0] {ddrIdle, ddrBusy, ddrDone} ddrState_e;

	logic                     clock = 1'b0;
	logic                     rstN;
	logic [31:0]              memAddr;
	memOpm_e                  memOpm;
	tileWord_u                memDataIn;
	tileWord_u                memDataOut;
	memOk_e                   memOk;
	ddrCmd_s                  ddrCmd;
	logic [`L2_BEAT_BITS-1:0] ddrDataIn = '0;
	memOk_e                   ddrOk = OK_READY;

	traceEntry_s traceQ [$];
	logic        traceLoaded = 1'b0;
	int          valueErrs = 0;
	int          otherErrs = 0;
	int          reqCount = 0;

	logic [`L2_BEAT_BITS-1:0] ddrMem [logic [31:0]];
	ddrState_e ddrState = ddrIdle;
	int        stallLeft = 0;
	int        curStall;
	int        ddrWrBeats = 0;
	int        ddrRdBeats = 0;

	always #2 clock = ~clock;

	l2TileCache dut (
		.clock, .rstN,
		.memAddr, .memOpm, .memDataIn, .memDataOut, .memOk,
		.ddrCmd, .ddrDataIn, .ddrOk
	);

	// untouched DDR words read back as their own address
	function automatic logic [`L2_BEAT_BITS-1:0] ddrPattern(input logic [31:0] addr);
		logic [63:0] word;
		word = {addr, ~addr};
		return word[`L2_BEAT_BITS-1:0];
	endfunction

	//////////////////////////////
	// DDR model
	//////////////////////////////

	always @(negedge clock)
	begin
		if (!rstN)
		begin
			ddrState = ddrIdle;
			ddrOk <= OK_READY;
		end
		else if (ddrState == ddrDone)
		begin
			if (ddrCmd.opm == OPM_READY)
			begin
				ddrOk <= OK_READY;
				ddrState = ddrIdle;
			end
		end
		else if (ddrCmd.opm == OPM_READY)
		begin
			ddrOk <= OK_READY;    // beat dropped by the cache
			ddrState = ddrIdle;
		end
		else
		begin
			if (ddrState == ddrIdle)
			begin
				stallLeft = curStall;
				ddrState = ddrBusy;
			end
			if (stallLeft > 0)
			begin
				ddrOk <= OK_HOLD;
				stallLeft--;
			end
			else
			begin
				if (ddrCmd.opm == OPM_WR_TILE)
				begin
					ddrMem[ddrCmd.addr] = ddrCmd.data;
					ddrWrBeats++;
				end
				else
				begin
					ddrDataIn <= ddrMem.exists(ddrCmd.addr) ? ddrMem[ddrCmd.addr]
						: ddrPattern(ddrCmd.addr);
					ddrRdBeats++;
				end
				ddrOk <= OK_OK;
				ddrState = ddrDone;
			end
		end
	end

	//////////////////////////////
	// trace and requests
	//////////////////////////////

	task automatic loadTrace();
		int           fd;
		int           n;
		string        line;
		logic [7:0]   opChar;
		logic [39:0]  statusWord;
		logic [31:0]  addr;
		logic [127:0] wrTile;
		logic [127:0] expTile;
		int           stall;
		int           wrBeats;
		int           rdBeats;
		traceEntry_s  ent;

		fd = $fopen(tracePath, "r");
		if (fd == 0)
		begin
			$display("could not open the trace file %s", tracePath);
			otherErrs++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %h %h %s %h %d %d %d", opChar, addr, wrTile,
				statusWord, expTile, stall, wrBeats, rdBeats);
			if (n == 8)
			begin
				ent.isWrite  = (opChar == "W");
				ent.addr     = addr;
				ent.wrTile   = wrTile;
				ent.expFault = (statusWord == "FAULT");
				ent.expTile  = expTile;
				ent.stall    = stall;
				ent.wrBeats  = wrBeats;
				ent.rdBeats  = rdBeats;
				traceQ.push_back(ent);
			end
			else if (n > 0)
			begin
				$display("trace line could not be read: %s", line);
				otherErrs++;
			end
		end
		$fclose(fd);
	endtask

	task automatic runRequest(input traceEntry_s ent, input int ix);
		string     testName;
		int        wrBefore;
		int        rdBefore;
		memOk_e    expOk;
		memOk_e    gotOk;
		tileWord_u gotTile;

		testName = $sformatf("req%0d_%s_%08h", ix, ent.isWrite ? "W" : "R", ent.addr);
		expOk    = ent.expFault ? OK_FAULT : OK_OK;
		wrBefore = ddrWrBeats;
		rdBefore = ddrRdBeats;
		curStall = ent.stall;

		memAddr   = ent.addr;
		memOpm    = ent.isWrite ? OPM_WR_TILE : OPM_RD_TILE;
		memDataIn = ent.wrTile;
		do
			@(negedge clock);
		while (memOk != OK_OK && memOk != OK_FAULT);
		gotOk   = memOk;
		gotTile = memDataOut;

		memOpm    = OPM_READY;    // one idle cycle before the next request
		memDataIn = '0;
		@(negedge clock);

		assert (gotOk == expOk) else
		begin
			$display("ERR %s status expected %s actual %s", testName, expOk.name(), gotOk.name());
			valueErrs++;
		end
		if (!ent.isWrite && !ent.expFault)
		begin
			assert (gotTile == ent.expTile) else
			begin
				$display("ERR %s tile expected %h actual %h", testName, ent.expTile, gotTile);
				valueErrs++;
			end
		end
		assert (ddrWrBeats - wrBefore == ent.wrBeats) else
		begin
			$display("ERR %s write beats expected %0d actual %0d", testName, ent.wrBeats,
				ddrWrBeats - wrBefore);
			valueErrs++;
		end
		assert (ddrRdBeats - rdBefore == ent.rdBeats) else
		begin
			$display("ERR %s read beats expected %0d actual %0d", testName, ent.rdBeats,
				ddrRdBeats - rdBefore);
			valueErrs++;
		end
		assert (memOk == OK_READY) else
		begin
			$display("ERR %s idle memOk expected OK_READY actual %s", testName, memOk.name());
			valueErrs++;
		end
	endtask

	initial
	begin
		rstN      = 1'b0;
		memAddr   = '0;
		memOpm    = OPM_READY;
		memDataIn = '0;
		curStall  = 0;
		loadTrace();
		traceLoaded = 1'b1;
		if (traceQ.size() == 0)
		begin
			$display("the trace holds no requests");
			otherErrs++;
		end

		repeat (5) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		@(negedge clock);
		assert (memOk == OK_READY) else
		begin
			$display("ERR reset memOk expected OK_READY actual %s", memOk.name());
			valueErrs++;
		end
		assert (ddrCmd.opm == OPM_READY) else
		begin
			$display("ERR reset ddrCmd.opm expected OPM_READY actual %s", ddrCmd.opm.name());
			valueErrs++;
		end

		foreach (traceQ[i])
		begin
			runRequest(traceQ[i], i);
			reqCount++;
		end

		$display("errors: %0d wrong values, %0d other, %0d requests run",
			valueErrs, otherErrs, reqCount);
		if (valueErrs == 0 && otherErrs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog sized from the trace length
	initial
	begin
		int limitNs;
		wait (traceLoaded);
		limitNs = (traceQ.size() + 2) * maxReqCycles * clockPeriod;
		#(limitNs);
		$display("timeout: the requests did not finish within %0d ns", limitNs);
		$display("errors: %0d wrong values, %0d other, %0d requests run",
			valueErrs, otherErrs + 1, reqCount);
		$display("Verification failed");
		$finish;
	end

endmodule

/* verif/l2TileCache_trace.txt */
# op addr wrTile status expTile stall wrBeats rdBeats
# tiles in 128-bit hex, expTile checked on reads answered OK, stall is HOLD cycles per DDR beat
R 00001230 00000000000000000000000000000000 OK 00001238FFFFEDC700001230FFFFEDCF 0 0 2
R 00001230 00000000000000000000000000000000 OK 00001238FFFFEDC700001230FFFFEDCF 0 0 0
W 00001230 11111111222222223333333344444444 OK 00000000000000000000000000000000 0 0 0
R 00001230 00000000000000000000000000000000 OK 11111111222222223333333344444444 0 0 0
R 00005230 00000000000000000000000000000000 OK 00005238FFFFADC700005230FFFFADCF 0 2 2
R 00001230 00000000000000000000000000000000 OK 11111111222222223333333344444444 0 0 2
W 00001230 AAAAAAAABBBBBBBBCCCCCCCCDDDDDDDD OK 00000000000000000000000000000000 0 0 0
W 00009230 0123456789ABCDEF0F1E2D3C4B5A6978 OK 00000000000000000000000000000000 0 2 0
R 00001230 00000000000000000000000000000000 OK AAAAAAAABBBBBBBBCCCCCCCCDDDDDDDD 0 2 2
R 00009230 00000000000000000000000000000000 OK 0123456789ABCDEF0F1E2D3C4B5A6978 0 0 2
W 00002400 55555555666666667777777788888888 OK 00000000000000000000000000000000 0 0 0
R 00002400 00000000000000000000000000000000 OK 55555555666666667777777788888888 0 0 0
R 00003500 00000000000000000000000000000000 OK 00003508FFFFCAF700003500FFFFCAFF 0 0 2
W 00007500 FEDCBA98765432100123456789ABCDEF OK 00000000000000000000000000000000 0 0 0
R 00007500 00000000000000000000000000000000 OK FEDCBA98765432100123456789ABCDEF 0 0 0
W 00006400 9999999900000000EEEEEEEE12345678 OK 00000000000000000000000000000000 5 2 0
R 00002400 00000000000000000000000000000000 OK 55555555666666667777777788888888 0 2 2
R 00004600 00000000000000000000000000000000 OK 00004608FFFFB9F700004600FFFFB9FF 10 0 2
R 00004700 00000000000000000000000000000000 OK 00004708FFFFB8F700004700FFFFB8FF 23 0 2
R 00004800 00000000000000000000000000000000 FAULT 00000000000000000000000000000000 30 0 0
R 00004800 00000000000000000000000000000000 OK 00004808FFFFB7F700004800FFFFB7FF 0 0 2

/* verilog/l2TileCache.sv */
`timescale 1ns/1ps
`include "l2Tile_defines.svh"

module l2TileCache (
	input  logic                     clock,
	input  logic                     rstN,
	input  logic [31:0]              memAddr,
	input  l2TilePkg::memOpm_e       memOpm,
	input  l2TilePkg::tileWord_u     memDataIn,
	output l2TilePkg::tileWord_u     memDataOut,
	output l2TilePkg::memOk_e        memOk,
	output l2TilePkg::ddrCmd_s       ddrCmd,
	input  logic [`L2_BEAT_BITS-1:0] ddrDataIn,
	input  l2TilePkg::memOk_e        ddrOk
);
	import l2TilePkg::*;

	logic      hit;
	logic      victimDirty;
	logic      reqIsRead;
	logic      reqIsWrite;
	tileLine_s curLine;
	logic [31:0] reqAddr;

	logic      hold;
	storeCmd_s storeCmd;
	tileWord_u fillTile;

	logic captureVictim;
	logic fillBeat;
	logic [`L2_BEAT_BITS-1:0] beatOut;

	logic timerStart;
	logic beatDone;
	logic waitTick;
	logic [`L2_BEAT_IX_BITS-1:0] beatIx;
	logic lastBeat;
	logic expired;

	tileStore store (
		.clock, .rstN,
		.memAddr, .memOpm, .memDataIn,
		.hold, .storeCmd, .fillTile,
		.hit, .victimDirty, .reqIsRead, .reqIsWrite,
		.curLine, .reqAddr
	);

	transferTimer timer (
		.clock, .rstN,
		.start(timerStart), .beatDone, .waitTick,
		.beatIx, .lastBeat, .expired
	);

	tileAssembler assembler (
		.clock, .rstN,
		.captureVictim, .victimTile(curLine.data),
		.fillBeat, .beatIx, .ddrDataIn,
		.beatOut, .fillTile
	);

	missSequencer sequencer (
		.clock, .rstN,
		.hit, .victimDirty, .reqIsRead, .reqIsWrite,
		.curLine, .reqAddr, .beatOut, .beatIx, .lastBeat, .expired,
		.ddrOk, .memOk, .hold, .storeCmd,
		.captureVictim, .fillBeat,
		.timerStart, .beatDone, .waitTick,
		.ddrCmd
	);

	assign memDataOut = curLine.data;    // valid while memOk is OK on a read

endmodule

/* verilog/l2TilePkg.sv */
`include "l2Tile_defines.svh"

package l2TilePkg;

	typedef enum logic [4:0]
	{
		OPM_READY   = 5'b00000,
		OPM_RD_TILE = 5'b10111,
		OPM_WR_TILE = 5'b11111
	} memOpm_e;

	// any opcode with nonzero top bits is a live request
	function automatic logic isMemReq(memOpm_e opm);
		return opm[4:3] != 2'b00;
	endfunction

	typedef enum logic [1:0]
	{
		OK_READY = 2'b00,
		OK_OK    = 2'b01,
		OK_HOLD  = 2'b10,
		OK_FAULT = 2'b11
	} memOk_e;

	// whole tile for the requester, beat words for the DDR side
	typedef union packed
	{
		logic [127:0] tile;
		logic [`L2_BEATS-1:0][`L2_BEAT_BITS-1:0] beat;
	} tileWord_u;

	typedef struct packed
	{
		logic valid;
		logic dirty;
		logic [`L2_TAG_BITS-1:0] tag;
		tileWord_u data;
	} tileLine_s;

	typedef struct packed
	{
		logic en;
		logic dirty;
		logic useFill;     // fill tile instead of requester data
	} storeCmd_s;

	typedef struct packed
	{
		memOpm_e opm;
		logic [31:0] addr;
		logic [`L2_BEAT_BITS-1:0] data;
	} ddrCmd_s;

endpackage

/* verilog/l2Tile_defines.svh */
`ifndef L2_TILE_DEFINES_SVH
`define L2_TILE_DEFINES_SVH

//////////////////////////////
// cache geometry
//////////////////////////////

// log2 of the tile count, 8, 10 or 12
`define L2_IDX_BITS 8

// tiles are 16 bytes, so the tag takes what is left of a 28-bit tile address
`define L2_TAG_BITS (28 - `L2_IDX_BITS)

//////////////////////////////
// DDR side
//////////////////////////////

`define L2_BEAT_BITS 64                       // 64 or 32
`define L2_BEATS (128 / `L2_BEAT_BITS)        // beats per tile
`define L2_BEAT_IX_BITS $clog2(`L2_BEATS)

// cycles a single beat may wait before the request is abandoned
`define L2_DDR_TIMEOUT 24

`endif

/* verilog/missSequencer.sv */
`timescale 1ns/1ps
`include "l2Tile_defines.svh"

module missSequencer (
	input  logic                        clock,
	input  logic                        rstN,
	input  logic                        hit,
	input  logic                        victimDirty,
	input  logic                        reqIsRead,
	input  logic                        reqIsWrite,
	input  l2TilePkg::tileLine_s        curLine,
	input  logic [31:0]                 reqAddr,
	input  logic [`L2_BEAT_BITS-1:0]    beatOut,
	input  logic [`L2_BEAT_IX_BITS-1:0] beatIx,
	input  logic                        lastBeat,
	input  logic                        expired,
	input  l2TilePkg::memOk_e           ddrOk,
	output l2TilePkg::memOk_e           memOk,
	output logic                        hold,
	output l2TilePkg::storeCmd_s        storeCmd,
	output logic                        captureVictim,
	output logic                        fillBeat,
	output logic                        timerStart,
	output logic                        beatDone,
	output logic                        waitTick,
	output l2TilePkg::ddrCmd_s          ddrCmd
);
	import l2TilePkg::*;

	localparam int beatBytes = `L2_BEAT_BITS / 8;

	typedef enum logic [2:0]
	{
		stIdle, stWbIssue, stWbWait, stFillIssue, stFillWait, stInstall, stAnswer, stFault
	} seqState_e;

	seqState_e state;
	seqState_e nextState;

	logic [31:0] beatOfs;
	logic [31:0] victimBase;
	logic [31:0] fillBase;

	assign beatOfs    = 32'(beatIx) * 32'(beatBytes);
	assign victimBase = {curLine.tag, reqAddr[`L2_IDX_BITS+3:4], 4'h0};
	assign fillBase   = {reqAddr[31:4], 4'h0};

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState     = state;
		memOk         = OK_HOLD;
		hold          = 1'b1;
		storeCmd      = '0;
		captureVictim = 1'b0;
		fillBeat      = 1'b0;
		timerStart    = 1'b0;
		beatDone      = 1'b0;
		waitTick      = 1'b0;
		ddrCmd.opm    = OPM_READY;
		ddrCmd.addr   = '0;
		ddrCmd.data   = '0;

		case (state)
			stIdle:
			begin
				hold  = 1'b0;
				memOk = OK_READY;
				if (reqIsRead || reqIsWrite)
				begin
					if (hit)
					begin
						memOk          = OK_OK;
						storeCmd.en    = reqIsWrite;    // write hit just overwrites
						storeCmd.dirty = 1'b1;
					end
					else
					begin
						memOk         = OK_HOLD;
						hold          = 1'b1;
						captureVictim = 1'b1;
						timerStart    = 1'b1;
						if (victimDirty)
							nextState = stWbIssue;
						else if (reqIsRead)
							nextState = stFillIssue;
						else
							nextState = stInstall;    // full-tile write needs no fill
					end
				end
			end

			//////////////////////////////
			// DDR beats
			//////////////////////////////

			stWbIssue:
			begin
				ddrCmd.opm  = OPM_WR_TILE;
				ddrCmd.addr = victimBase + beatOfs;
				ddrCmd.data = beatOut;
				if (ddrOk == OK_OK)
					nextState = stWbWait;
				else
				begin
					waitTick = 1'b1;
					if (expired)
						nextState = stFault;
				end
			end

			stWbWait, stFillWait:
			begin
				if (ddrOk == OK_READY)
				begin
					beatDone = 1'b1;
					if (!lastBeat)
						nextState = (state == stWbWait) ? stWbIssue : stFillIssue;
					else if (state == stWbWait && reqIsRead)
						nextState = stFillIssue;
					else
						nextState = stInstall;
				end
				else
				begin
					waitTick = 1'b1;
					if (expired)
						nextState = stFault;
				end
			end

			stFillIssue:
			begin
				ddrCmd.opm  = OPM_RD_TILE;
				ddrCmd.addr = fillBase + beatOfs;
				if (ddrOk == OK_OK)
				begin
					fillBeat  = 1'b1;    // beat data is valid with OK
					nextState = stFillWait;
				end
				else
				begin
					waitTick = 1'b1;
					if (expired)
						nextState = stFault;
				end
			end

			stInstall:
			begin
				storeCmd.en      = 1'b1;
				storeCmd.dirty   = reqIsWrite;
				storeCmd.useFill = reqIsRead;
				nextState        = stAnswer;
			end

			stAnswer:
			begin
				hold      = 1'b0;
				memOk     = OK_OK;
				nextState = stIdle;
			end

			// line left as it was and the DDR request already dropped
			stFault:
			begin
				hold      = 1'b0;
				memOk     = OK_FAULT;
				nextState = stIdle;
			end

			default:
				nextState = stIdle;
		endcase
	end

endmodule

/* verilog/tileAssembler.sv */
`timescale 1ns/1ps
`include "l2Tile_defines.svh"

module tileAssembler (
	input  logic                        clock,
	input  logic                        rstN,
	input  logic                        captureVictim,
	input  l2TilePkg::tileWord_u        victimTile,
	input  logic                        fillBeat,
	input  logic [`L2_BEAT_IX_BITS-1:0] beatIx,
	input  logic [`L2_BEAT_BITS-1:0]    ddrDataIn,
	output logic [`L2_BEAT_BITS-1:0]    beatOut,
	output l2TilePkg::tileWord_u        fillTile
);
	import l2TilePkg::*;

	tileWord_u victimQ;
	tileWord_u fillQ;

	//////////////////////////////
	// writeback side
	//////////////////////////////

	// private copy as the store line may be replaced before the last beat leaves
	always_ff @(posedge clock)
	begin
		if (captureVictim)
			victimQ <= victimTile;
	end

	assign beatOut = victimQ.beat[beatIx];

	//////////////////////////////
	// fill side
	//////////////////////////////

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			fillQ <= '0;
		else if (fillBeat)
			fillQ.beat[beatIx] <= ddrDataIn;    // slot follows the beat order
	end

	assign fillTile = fillQ;

endmodule

/* verilog/tileStore.sv */
`timescale 1ns/1ps
`include "l2Tile_defines.svh"

module tileStore (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [31:0]           memAddr,
	input  l2TilePkg::memOpm_e    memOpm,
	input  l2TilePkg::tileWord_u  memDataIn,
	input  logic                  hold,
	input  l2TilePkg::storeCmd_s  storeCmd,
	input  l2TilePkg::tileWord_u  fillTile,
	output logic                  hit,
	output logic                  victimDirty,
	output logic                  reqIsRead,
	output logic                  reqIsWrite,
	output l2TilePkg::tileLine_s  curLine,
	output logic [31:0]           reqAddr
);
	import l2TilePkg::*;

	localparam int numTiles = 1 << `L2_IDX_BITS;

	logic [`L2_TAG_BITS-1:0] tagArr [numTiles];
	logic                    dirtyArr [numTiles];
	tileWord_u               dataArr [numTiles];
	logic [numTiles-1:0]     validVec;

	memOpm_e   reqOpm;
	tileWord_u reqData;

	logic [`L2_IDX_BITS-1:0] rdIdx;
	logic [`L2_IDX_BITS-1:0] wrIdx;
	logic [`L2_TAG_BITS-1:0] wrTag;
	tileWord_u               wrData;
	logic                    bypass;

	logic                    lineValid;
	logic                    lineDirty;
	logic [`L2_TAG_BITS-1:0] lineTag;
	tileWord_u               lineData;

	assign rdIdx  = memAddr[`L2_IDX_BITS+3:4];
	assign wrIdx  = reqAddr[`L2_IDX_BITS+3:4];
	assign wrTag  = reqAddr[31:`L2_IDX_BITS+4];
	assign wrData = storeCmd.useFill ? fillTile : reqData;
	assign bypass = storeCmd.en && (wrIdx == rdIdx);    // install lands in the line being read

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			reqOpm <= OPM_READY;
		else if (!hold)
			reqOpm <= memOpm;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			reqAddr <= memAddr;
			reqData <= memDataIn;
		end
	end

	//////////////////////////////
	// line arrays
	//////////////////////////////

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			validVec  <= '0;
			lineValid <= 1'b0;
		end
		else
		begin
			if (storeCmd.en)
				validVec[wrIdx] <= 1'b1;
			lineValid <= bypass ? 1'b1 : validVec[rdIdx];
		end
	end

	always_ff @(posedge clock)
	begin
		if (storeCmd.en)
		begin
			tagArr[wrIdx]   <= wrTag;
			dirtyArr[wrIdx] <= storeCmd.dirty;
			dataArr[wrIdx]  <= wrData;
		end
		lineTag   <= bypass ? wrTag : tagArr[rdIdx];
		lineDirty <= bypass ? storeCmd.dirty : dirtyArr[rdIdx];
		lineData  <= bypass ? wrData : dataArr[rdIdx];
	end

	always_comb
	begin
		curLine.valid = lineValid;
		curLine.dirty = lineDirty;
		curLine.tag   = lineTag;
		curLine.data  = lineData;
	end

	assign reqIsRead   = (reqOpm == OPM_RD_TILE);
	assign reqIsWrite  = (reqOpm == OPM_WR_TILE);
	assign hit         = isMemReq(reqOpm) && lineValid && (lineTag == wrTag);
	assign victimDirty = lineValid && lineDirty;

endmodule

/* verilog/transferTimer.sv */
`timescale 1ns/1ps
`include "l2Tile_defines.svh"

module transferTimer (
	input  logic                        clock,
	input  logic                        rstN,
	input  logic                        start,
	input  logic                        beatDone,
	input  logic                        waitTick,
	output logic [`L2_BEAT_IX_BITS-1:0] beatIx,
	output logic                        lastBeat,
	output logic                        expired
);

	localparam int waitBits = $clog2(`L2_DDR_TIMEOUT + 1);

	logic [waitBits-1:0] waitCnt;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			beatIx  <= '0;
			waitCnt <= '0;
		end
		else if (start)
		begin
			beatIx  <= '0;
			waitCnt <= '0;
		end
		else
		begin
			if (beatDone)
				beatIx <= beatIx + 1'b1;    // wraps to zero after the last beat

			// each beat gets a fresh wait budget
			if (beatDone)
				waitCnt <= '0;
			else if (waitTick && !expired)
				waitCnt <= waitCnt + 1'b1;
		end
	end

	assign lastBeat = (beatIx == `L2_BEAT_IX_BITS'(`L2_BEATS - 1));
	assign expired  = (waitCnt >= waitBits'(`L2_DDR_TIMEOUT));

endmodule
